// ==== design/fir_pkg.sv ====
/* Shared data, coefficient and accumulator widths, output scaling,
   sequencer states and MAC opcodes */

package fir_pkg;

	// Datapath widths
	localparam int DATA_W = 16;              // Signed input sample
	localparam int COEF_W = 16;              // Signed coefficient
	localparam int PROD_W = DATA_W + COEF_W; // Full precision product
	localparam int ACC_W  = PROD_W + 6;      // Headroom for up to 64 taps

	// Arithmetic right shift ahead of the 16-bit saturation
	localparam int OUT_SHIFT = 15;

	// Sequencer control states
	typedef enum logic [1:0] {
		SEQ_IDLE, // Ready, waiting for a sample
		SEQ_TAPS, // Issuing taps 0 .. N-2
		SEQ_LAST  // Issuing the final tap
	} seq_state_t;

	// Opcodes for the multiply-accumulate unit
	typedef enum logic [1:0] {
		MAC_NOP,   // Hold accumulator
		MAC_FIRST, // Load product, starts a new sum
		MAC_ACC,   // Add product
		MAC_LAST   // Add product and flag the sum as complete
	} mac_op_t;

	// Opcode sequence per sample:
	//   tap 0           -> MAC_FIRST
	//   taps 1 .. N-2   -> MAC_ACC
	//   tap N-1         -> MAC_LAST
	// Idle cycles carry MAC_NOP so the accumulator holds

endpackage

// ==== design/fir_sequencer.sv ====
/* Control FSM of the FIR core: input handshake, memory write strobes,
   tap index counter and the MAC opcode stream */

module fir_sequencer #(
	parameter  int N_TAPS = 16,
	localparam int TAP_AW = $clog2(N_TAPS)
) (
	input  logic               alu_clk,
	input  logic               clk_fast,  // Async reset, active low
	input  logic               valid_in,  // Sample offered
	input  logic               cload,     // Coefficient write request
	output logic               din_ready, // High while idle
	output logic               sample_wr, // Accepting edge
	output logic               coef_wr,   // Load allowed only when idle
	output logic [TAP_AW-1:0]  tap_index, // Tap being read this cycle
	output fir_pkg::mac_op_t   mac_op     // One cycle behind tap_index
);
	import fir_pkg::*;

	// Counter value of the tap before the last one
	localparam logic [TAP_AW-1:0] PRELAST_CNT = TAP_AW'(N_TAPS - 2);

	seq_state_t        state;
	logic [TAP_AW-1:0] tap_cnt;  // Tap walked this cycle
	mac_op_t           op_issue; // Opcode for tap_cnt, before alignment

	// Handshake and write strobes
	assign din_ready = (state == SEQ_IDLE);
	assign sample_wr = din_ready & valid_in;
	assign coef_wr   = din_ready & cload; // Busy loads dropped here

	assign tap_index = tap_cnt;

	// State and tap counter
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			state   <= SEQ_IDLE;
			tap_cnt <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					tap_cnt <= '0; // Tap 0 presented right after acceptance
					if (valid_in) begin
						state <= SEQ_TAPS;
					end
				end
				SEQ_TAPS: begin
					tap_cnt <= tap_cnt + 1'b1;
					if (tap_cnt == PRELAST_CNT) begin
						state <= SEQ_LAST; // Next tap is N-1
					end
				end
				SEQ_LAST: begin
					state   <= SEQ_IDLE; // Ready again, MAC still draining
					tap_cnt <= '0;
				end
				default: begin
					state   <= SEQ_IDLE;
					tap_cnt <= '0;
				end
			endcase
		end
	end

	// Opcode for the tap on tap_index
	always_comb begin
		case (state)
			SEQ_TAPS: begin
				if (tap_cnt == '0) begin
					op_issue = MAC_FIRST; // Fresh sum
				end else begin
					op_issue = MAC_ACC;
				end
			end
			SEQ_LAST: op_issue = MAC_LAST;
			default:  op_issue = MAC_NOP; // Idle
		endcase
	end

	// Delay by the memory read latency
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			mac_op <= MAC_NOP;
		end else begin
			mac_op <= op_issue;
		end
	end

endmodule

// ==== design/fir_tap_memory.sv ====
/* Coefficient memory and circular sample buffer of the FIR core
   Write pointer handling and the registered tap read */

module fir_tap_memory #(
	parameter  int N_TAPS = 16,
	localparam int TAP_AW = $clog2(N_TAPS)
) (
	input  logic                       alu_clk,
	input  logic                       clk_fast,  // Async reset, active low
	input  logic [fir_pkg::DATA_W-1:0] din,
	input  logic                       sample_wr, // Push din into the buffer
	input  logic [fir_pkg::COEF_W-1:0] cin,
	input  logic [5:0]                 caddr,
	input  logic                       coef_wr,   // Write cin to slot caddr
	input  logic [TAP_AW-1:0]          tap_index,
	output logic [fir_pkg::DATA_W-1:0] sample_q,  // x[n-k], one cycle later
	output logic [fir_pkg::COEF_W-1:0] coef_q     // c[k], one cycle later
);
	import fir_pkg::*;

	localparam logic [TAP_AW:0]   DEPTH    = (TAP_AW + 1)'(N_TAPS);
	localparam logic [TAP_AW-1:0] TOP_SLOT = TAP_AW'(N_TAPS - 1);

	logic [DATA_W-1:0] sample_mem [N_TAPS];
	logic [COEF_W-1:0] coef_mem   [N_TAPS];
	logic [TAP_AW-1:0] wr_ptr;   // Slot of the newest sample
	logic [TAP_AW-1:0] wr_next;  // Slot the next sample goes to
	logic [TAP_AW:0]   rd_wrap;  // Read slot after wrapping below zero
	logic [TAP_AW-1:0] rd_slot;
	logic              caddr_ok; // Address inside the filter length

	// Modulo N_TAPS pointer arithmetic, N need not be a power of two
	assign wr_next  = (wr_ptr == TOP_SLOT) ? '0 : wr_ptr + 1'b1;
	assign rd_wrap  = {1'b0, wr_ptr} + DEPTH - {1'b0, tap_index};
	assign rd_slot  = (wr_ptr >= tap_index) ? wr_ptr - tap_index : rd_wrap[TAP_AW-1:0];
	assign caddr_ok = ({1'b0, caddr} < 7'(N_TAPS));

	// Writes, history starts all zero
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			wr_ptr <= '0;
			for (int i = 0; i < N_TAPS; i++) begin
				sample_mem[i] <= '0;
				coef_mem[i]   <= '0;
			end
		end else begin
			if (sample_wr) begin
				sample_mem[wr_next] <= din;
				wr_ptr              <= wr_next; // Advance on each sample
			end
			if (coef_wr && caddr_ok) begin
				coef_mem[caddr[TAP_AW-1:0]] <= cin; // Out of range dropped
			end
		end
	end

	// Synchronous tap read
	always_ff @(posedge alu_clk) begin
		sample_q <= sample_mem[rd_slot];
		coef_q   <= coef_mem[tap_index];
	end

endmodule

// ==== design/fir_mac.sv ====
/* Two-stage multiply-accumulate unit of the FIR core
   Registered product, opcode-driven accumulator and done strobe */

module fir_mac (
	input  logic                       alu_clk,
	input  logic                       clk_fast, // Async reset, active low
	input  logic [fir_pkg::DATA_W-1:0] sample_q, // Signed sample
	input  logic [fir_pkg::COEF_W-1:0] coef_q,   // Signed coefficient
	input  fir_pkg::mac_op_t           mac_op,   // Aligned with the operands
	output logic [fir_pkg::ACC_W-1:0]  acc_q,    // Running sum
	output logic                       acc_done  // Sum in acc_q is complete
);
	import fir_pkg::*;

	logic signed [PROD_W-1:0] prod_q;   // Stage 1 product
	mac_op_t                  op_q;     // Opcode travelling with prod_q
	logic        [ACC_W-1:0]  prod_ext; // Sign extended to the accumulator

	// Stage 1, multiply
	always_ff @(posedge alu_clk) begin
		prod_q <= $signed(sample_q) * $signed(coef_q);
	end

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			op_q <= MAC_NOP;
		end else begin
			op_q <= mac_op;
		end
	end

	assign prod_ext = {{(ACC_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

	// Stage 2, accumulate
	// A new sum may enter stage 1 while stage 2 finishes the old one
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			acc_q    <= '0;
			acc_done <= 1'b0;
		end else begin
			case (op_q)
				MAC_FIRST: acc_q <= prod_ext;         // Restart
				MAC_ACC:   acc_q <= acc_q + prod_ext;
				MAC_LAST:  acc_q <= acc_q + prod_ext; // Final tap
				default:   acc_q <= acc_q;            // Hold
			endcase
			acc_done <= (op_q == MAC_LAST); // Single-cycle pulse
		end
	end

endmodule

// ==== design/fir_output_stage.sv ====
/* Result stage of the FIR core: arithmetic shift, saturation to 16 bits,
   output registers and the valid strobe */

module fir_output_stage (
	input  logic                       alu_clk,
	input  logic                       clk_fast, // Async reset, active low
	input  logic [fir_pkg::ACC_W-1:0]  acc_q,    // Accumulator from the MAC
	input  logic                       acc_done, // acc_q holds a finished sum
	output logic [fir_pkg::DATA_W-1:0] dout,     // Held until next strobe
	output logic                       valid,    // One-cycle strobe
	output logic [fir_pkg::ACC_W-1:0]  dout_raw  // Unsaturated sum
);
	import fir_pkg::*;

	localparam int HI_W = ACC_W - DATA_W + 1; // Bits that must match the sign

	logic signed [ACC_W-1:0]  shifted;
	logic        [HI_W-1:0]   hi_bits;
	logic                     in_range;
	logic        [DATA_W-1:0] sat_val;

	// Scale, then clamp to the signed 16-bit range
	assign shifted  = $signed(acc_q) >>> OUT_SHIFT;
	assign hi_bits  = shifted[ACC_W-1:DATA_W-1];
	assign in_range = (&hi_bits) | ~(|hi_bits); // All ones or all zeros
	assign sat_val  = in_range ? shifted[DATA_W-1:0] :
		(shifted[ACC_W-1] ? {1'b1, {(DATA_W - 1){1'b0}}}  // -32768
		                  : {1'b0, {(DATA_W - 1){1'b1}}}); // +32767

	// Result registers, loaded only on a finished sum
	always_ff @(posedge alu_clk) begin
		if (acc_done) begin
			dout     <= sat_val;
			dout_raw <= acc_q;
		end
	end

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			valid <= 1'b0;
		end else begin
			valid <= acc_done;
		end
	end

endmodule

// ==== design/fir_top.sv ====
/* Top level of the time-multiplexed FIR core
   Sequencer, tap memory, MAC and output stage wired together */

module fir_top #(
	parameter int N_TAPS = 16 // Filter length, 2 .. 64
) (
	input  logic                       alu_clk,   // Core clock
	input  logic                       clk_fast,  // Async reset, active low
	input  logic [fir_pkg::DATA_W-1:0] din,       // Input sample
	input  logic                       valid_in,  // Sample offered
	input  logic [fir_pkg::COEF_W-1:0] cin,       // Coefficient value
	input  logic [5:0]                 caddr,     // Coefficient slot
	input  logic                       cload,     // Coefficient write request
	output logic                       din_ready, // Idle, sample or load accepted
	output logic [fir_pkg::DATA_W-1:0] dout,      // Scaled, saturated result
	output logic                       valid,     // One-cycle result strobe
	output logic [fir_pkg::ACC_W-1:0]  dout_raw   // Full accumulator value
);
	import fir_pkg::*;

	localparam int TAP_AW = $clog2(N_TAPS);

	// Sequencer to tap memory
	logic              sample_wr;
	logic              coef_wr;
	logic [TAP_AW-1:0] tap_index;

	// Tap memory to MAC
	logic [DATA_W-1:0] sample_q;
	logic [COEF_W-1:0] coef_q;

	// Sequencer to MAC, already aligned with the read data
	mac_op_t mac_op;

	// MAC to output stage
	logic [ACC_W-1:0] acc_q;
	logic             acc_done;

	// Decode
	fir_sequencer #(
		.N_TAPS (N_TAPS)
	) u_sequencer (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.valid_in  (valid_in),
		.cload     (cload),
		.din_ready (din_ready),
		.sample_wr (sample_wr),
		.coef_wr   (coef_wr),
		.tap_index (tap_index),
		.mac_op    (mac_op)
	);

	// Coefficients and sample history
	fir_tap_memory #(
		.N_TAPS (N_TAPS)
	) u_tap_memory (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.din       (din),
		.sample_wr (sample_wr),
		.cin       (cin),
		.caddr     (caddr),
		.coef_wr   (coef_wr),
		.tap_index (tap_index),
		.sample_q  (sample_q),
		.coef_q    (coef_q)
	);

	// Execute
	fir_mac u_mac (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.sample_q (sample_q),
		.coef_q   (coef_q),
		.mac_op   (mac_op),
		.acc_q    (acc_q),
		.acc_done (acc_done)
	);

	// Result
	fir_output_stage u_output_stage (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.acc_q    (acc_q),
		.acc_done (acc_done),
		.dout     (dout),
		.valid    (valid),
		.dout_raw (dout_raw)
	);

endmodule

// ==== testbench/tb_fir.sv ====
/* Testbench for the FIR core: clock and reset, file-driven coefficient loads
   and samples, result monitor with latency, value and ordering checks */

module tb_fir;
	timeunit 1ns;
	timeprecision 1ps;

	import fir_pkg::*;

	localparam int N_TAPS     = 16;
	localparam int LATENCY    = N_TAPS + 4; // Falling edges from drive to strobe
	localparam int WAIT_LIMIT = 200;        // Cycles any single wait may take

	logic              alu_clk;
	logic              clk_fast;
	logic [DATA_W-1:0] din;
	logic              valid_in;
	logic [COEF_W-1:0] cin;
	logic [5:0]        caddr;
	logic              cload;
	logic              din_ready;
	logic [DATA_W-1:0] dout;
	logic              valid;
	logic [ACC_W-1:0]  dout_raw;

	// Outstanding results, oldest first
	longint exp_dout_q[$];
	longint exp_raw_q[$];
	int     start_q[$];  // Cycle count at the drive edge
	string  name_q[$];
	int     cyc = 0;

	initial alu_clk = 1'b0;
	always #50 alu_clk = ~alu_clk; // 100 ns period

	always @(posedge alu_clk) cyc <= cyc + 1; // Stable at falling edges

	fir_top #(
		.N_TAPS (N_TAPS)
	) fir_top_inst (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.din       (din),
		.valid_in  (valid_in),
		.cin       (cin),
		.caddr     (caddr),
		.cload     (cload),
		.din_ready (din_ready),
		.dout      (dout),
		.valid     (valid),
		.dout_raw  (dout_raw)
	);

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch: %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	// Poll din_ready at falling edges until it reaches level
	task automatic wait_ready(input logic level, input string what);
		int waited;
		waited = 0;
		while (din_ready !== level) begin
			@(negedge alu_clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure({"Timeout waiting for din_ready ", what});
			end
		end
	endtask

	// Wait until the monitor has seen every outstanding result
	task automatic wait_results();
		int waited;
		waited = 0;
		while (name_q.size() != 0) begin
			@(posedge alu_clk); // Queue only changes at falling edges
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure("Timeout waiting for valid on outstanding results");
			end
		end
		@(negedge alu_clk);
	endtask

	task automatic send_sample(input longint sample, input longint exp_d, input longint exp_r,
			input bit hold, input string name);
		din      = sample[DATA_W-1:0];
		valid_in = 1'b1;
		wait_ready(1'b1, {"to accept ", name});
		exp_dout_q.push_back(exp_d); // Accepted at the next rising edge
		exp_raw_q.push_back(exp_r);
		start_q.push_back(cyc);
		name_q.push_back(name);
		@(negedge alu_clk);
		check_value({name, " din_ready after accept"}, 0, din_ready);
		if (!hold) begin
			valid_in = 1'b0;
		end
	endtask

	task automatic load_coef(input int addr, input longint value);
		wait_results();
		valid_in = 1'b0;
		wait_ready(1'b1, "before a coefficient load");
		caddr = addr[5:0];
		cin   = value[COEF_W-1:0];
		cload = 1'b1;
		@(negedge alu_clk);
		cload = 1'b0;
	endtask

	// Held for a few cycles, all inside the busy window
	task automatic load_while_busy(input int addr, input longint value);
		valid_in = 1'b0;
		wait_ready(1'b0, "to drop before a busy load");
		caddr = addr[5:0];
		cin   = value[COEF_W-1:0];
		cload = 1'b1;
		for (int i = 0; i < 3; i++) begin
			check_value("din_ready during busy load", 0, din_ready);
			@(negedge alu_clk);
		end
		cload = 1'b0;
	endtask

	// Result monitor, one expected entry per strobe
	always @(negedge alu_clk) begin
		if (clk_fast) begin
			if (valid) begin
				if (name_q.size() == 0) begin
					report_failure("Valid pulse with no sample outstanding");
				end else begin
					check_value({name_q[0], " latency"}, LATENCY, cyc - start_q[0]);
					check_value({name_q[0], " dout"}, exp_dout_q[0], longint'($signed(dout)));
					check_value({name_q[0], " dout_raw"}, exp_raw_q[0],
						longint'($signed(dout_raw)));
					void'(exp_dout_q.pop_front());
					void'(exp_raw_q.pop_front());
					void'(start_q.pop_front());
					void'(name_q.pop_front());
				end
			end else if (name_q.size() != 0 && cyc - start_q[0] >= LATENCY) begin
				report_failure({"No valid pulse in time for ", name_q[0]});
			end
		end
	end

	initial begin
		int               fd;
		int               code;
		int               n_samples;
		logic [63:0]      tag;
		logic [8*128-1:0] rest;   // Remainder of a comment line
		longint           f1;
		longint           f2;
		longint           f3;
		din       = '0;
		valid_in  = 1'b0;
		cin       = '0;
		caddr     = '0;
		cload     = 1'b0;
		clk_fast  = 1'b0; // Reset asserted
		n_samples = 0;
		repeat (16) @(negedge alu_clk);
		clk_fast = 1'b1;
		@(negedge alu_clk);
		check_value("reset din_ready", 1, din_ready);
		check_value("reset valid", 0, valid);

		fd = $fopen("testbench/fir_stimulus.txt", "r");
		if (fd == 0) begin
			report_failure("Cannot open testbench/fir_stimulus.txt");
		end
		tag  = '0;
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			if (tag == "#") begin
				code = $fgets(rest, fd); // Skip comment text
			end else if (tag == "C" || tag == "X") begin
				code = $fscanf(fd, "%d %d", f1, f2);
				if (code != 2) begin
					report_failure("Incomplete coefficient record in stimulus file");
				end
				if (tag == "C") begin
					load_coef(int'(f1), f2);
				end else begin
					load_while_busy(int'(f1), f2);
				end
			end else if (tag == "S" || tag == "B") begin
				code = $fscanf(fd, "%d %d %d", f1, f2, f3);
				if (code != 3) begin
					report_failure("Incomplete sample record in stimulus file");
				end
				send_sample(f1, f2, f3, tag == "B", $sformatf("sample %0d", n_samples));
				n_samples++;
				if (tag == "S") begin
					wait_results();
				end
			end else begin
				report_failure("Unknown record tag in stimulus file");
			end
			tag  = '0;
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);

		valid_in = 1'b0;
		wait_results();
		repeat (N_TAPS + 8) @(negedge alu_clk); // Room for a stray strobe to show
		if (n_samples == 0) begin
			report_failure("No sample records found in the stimulus file");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== project.f ====
design/fir_pkg.sv
design/fir_sequencer.sv
design/fir_tap_memory.sv
design/fir_mac.sv
design/fir_output_stage.sv
design/fir_top.sv
testbench/tb_fir.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the FIR testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_fir -f project.f -Mdir obj_dir -o Vtb_fir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_fir > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
	echo "FAIL"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

echo "PASS"
exit 0

// ==== testbench/fir_stimulus.txt ====
# Records: C addr coef | S sample dout dout_raw | B as S with valid_in held | X addr coef
# Values are signed decimal, X loads a coefficient while the core is busy
# Coefficients, slot 40 lies outside the filter and is dropped
C 0 24000
C 1 -16000
C 2 20000
C 3 -1000
C 15 3000
C 40 12345
# Impulse response
S 32767 23999 786408000
S 0 -16000 -524272000
S 0 19999 655340000
S 0 -1000 -32767000
# Mixed-sign convolution
S 1000 732 24000000
S -2000 -1954 -64000000
S 300 1806 59200000
S -4000 -4328 -141800000
S 5000 5859 192000000
S -100 -4966 -162700000
S 32767 27221 892008000
# Saturation in both directions
S -32768 -32768 -1317704000
S 32767 32767 1966136000
S -32768 -32768 -1998831000
# Slot 0 load while busy must leave the old coefficient
B 2000 32767 1260396000
X 0 5
S -500 -19343 -633826000
# Back-to-back, the sample buffer has wrapped
B 100 2538 83168000
B -200 -562 -18400000
B 300 393 12900000
B -400 -474 -15500000
